//--- design/cpu_alu.sv
// combinational ALU
// move, add, subtract, and, xor with next zero and carry flags
`timescale 1ns/100ps

module cpu_alu import cpu_cfg_pkg::*, cpu_isa_pkg::*; (
    input  opcode_e           alu_op,
    input  logic [DATA_W-1:0] op0,
    input  logic [DATA_W-1:0] op1,

    output logic [DATA_W-1:0] alu_dout,
    output logic              nx_z,
    output logic              nx_c
);

    logic [DATA_W:0] sum;
    logic [DATA_W:0] diff;

    // extra top bit gives the carry out
    assign sum  = {1'b0, op0} + {1'b0, op1};
    // and here the borrow when op1 exceeds op0
    assign diff = {1'b0, op0} - {1'b0, op1};

    always_comb begin
        alu_dout = op1;
        nx_c     = 1'b0;
        case (alu_op)
            OP_ADD: begin
                alu_dout = sum[DATA_W-1:0];
                nx_c     = sum[DATA_W];
            end
            OP_SUB: begin
                alu_dout = diff[DATA_W-1:0];
                nx_c     = diff[DATA_W];
            end
            OP_AND: begin
                alu_dout = op0 & op1;
            end
            OP_XOR: begin
                alu_dout = op0 ^ op1;
            end
            default: begin
                // MOV passes the source through
                alu_dout = op1;
            end
        endcase
    end

    assign nx_z = (alu_dout == '0);

endmodule

//--- design/cpu_cfg_pkg.sv
// core configuration constants
// data and address widths, register bank geometry,
// flag bit positions and the dump address of the flag byte
package cpu_cfg_pkg;

    // register and RAM word width
    parameter int DATA_W = 16;

    // RAM word address width
    parameter int ADDR_W = 24;

    // register select within one bank
    parameter int REG_SEL_W = 2;
    parameter int REGS_PER_BANK = 4;

    // positions inside the flag byte
    parameter int FLAG_Z = 0;
    parameter int FLAG_C = 1;

    // dump address returning the flag byte
    parameter logic [7:0] DMP_FLAGS_ADDR = 8'h20;

endpackage

//--- design/cpu_ctrl.sv
// fetch/execute sequencer of the core
// program counter, bank pointer, flag byte and halt state,
// RAM address and write strobe, register write port control
`timescale 1ns/100ps

module cpu_ctrl import cpu_cfg_pkg::*, cpu_isa_pkg::*; #(
    parameter int N_BANKS = 4,
    localparam int RFP_W = $clog2(N_BANKS)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,

    input  logic [DATA_W-1:0]    ram_dout,
    input  logic [DATA_W-1:0]    dst_out,
    input  logic [DATA_W-1:0]    alu_dout,
    input  logic                 nx_z,
    input  logic                 nx_c,

    output logic [ADDR_W-1:0]    ram_addr,
    output logic [DATA_W-1:0]    ram_din,
    output logic [1:0]           ram_we,

    output logic [RFP_W-1:0]     rfp,
    output logic                 reg_we,
    output logic [REG_SEL_W-1:0] reg_wsel,
    output logic [REG_SEL_W-1:0] src_sel,
    output logic [REG_SEL_W-1:0] dst_sel,
    output logic [DATA_W-1:0]    reg_wdata,
    output opcode_e              alu_op,
    output logic [7:0]           flags,
    output logic                 halted
);

    localparam logic [1:0] ST_FETCH = 2'd0;
    localparam logic [1:0] ST_EXEC  = 2'd1;
    localparam logic [1:0] ST_MEM   = 2'd2;

    logic [1:0]        state;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] imm_addr;
    instr_u            ir_q;
    instr_u            cur;
    opcode_e           op;
    logic              is_alu;

    // RAM output carries the fetched word during EXEC,
    // MEM works from the copy taken at the end of EXEC
    assign cur = (state == ST_EXEC) ? instr_u'(ram_dout) : ir_q;
    assign op  = cur.r.opcode;

    assign is_alu   = op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR};
    assign imm_addr = {{(ADDR_W-8){1'b0}}, cur.i.imm};

    assign src_sel  = cur.r.src;
    assign dst_sel  = cur.r.dst;
    assign reg_wsel = cur.r.dst;
    assign alu_op   = op;

    // ST stores the register named in the dst field
    assign ram_din = dst_out;

    always_comb begin
        ram_addr  = pc;
        ram_we    = 2'b00;
        reg_we    = 1'b0;
        reg_wdata = alu_dout;
        if (state == ST_EXEC) begin
            case (op)
                OP_LDI: begin
                    reg_we    = 1'b1;
                    reg_wdata = {{(DATA_W-8){1'b0}}, cur.i.imm};
                end
                OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                    reg_we = 1'b1;
                end
                OP_LD: begin
                    ram_addr = imm_addr;
                end
                OP_ST: begin
                    ram_addr = imm_addr;
                    ram_we   = 2'b11;
                end
                default: begin
                    reg_we = 1'b0;
                end
            endcase
        end else if (state == ST_MEM) begin
            // load data arrives one enabled cycle after the address
            reg_we    = 1'b1;
            reg_wdata = ram_dout;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_FETCH;
            pc     <= '0;
            rfp    <= '0;
            flags  <= '0;
            halted <= 1'b0;
            ir_q   <= '0;
        end else if (cen && !halted) begin
            case (state)
                ST_FETCH: begin
                    pc    <= pc + 1'b1;
                    state <= ST_EXEC;
                end
                ST_EXEC: begin
                    ir_q  <= cur;
                    state <= (op == OP_LD) ? ST_MEM : ST_FETCH;
                    if (op == OP_JP) begin
                        pc <= imm_addr;
                    end
                    if (op == OP_LDF) begin
                        rfp <= cur.i.bank[RFP_W-1:0];
                    end
                    if (op == OP_HALT) begin
                        halted <= 1'b1;
                    end
                    if (is_alu) begin
                        flags[FLAG_Z] <= nx_z;
                        flags[FLAG_C] <= nx_c;
                    end
                end
                default: begin
                    state <= ST_FETCH;
                end
            endcase
        end
    end

endmodule

//--- design/cpu_isa_pkg.sv
// instruction set definitions
// opcode encoding, the register and immediate instruction forms
// and the union that overlays both on one fetched word
package cpu_isa_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_LDI  = 4'h1,
        OP_MOV  = 4'h2,
        OP_ADD  = 4'h3,
        OP_SUB  = 4'h4,
        OP_AND  = 4'h5,
        OP_XOR  = 4'h6,
        OP_LDF  = 4'h7,
        OP_LD   = 4'h8,
        OP_ST   = 4'h9,
        OP_JP   = 4'ha,
        OP_HALT = 4'hf
    } opcode_e;

    // MOV and ALU operations
    typedef struct packed {
        opcode_e    opcode;
        logic [1:0] dst;
        logic [1:0] src;
        logic [7:0] unused;
    } instr_reg_t;

    // LDI, LDF, LD, ST and JP
    typedef struct packed {
        opcode_e    opcode;
        logic [1:0] dst;
        logic [1:0] bank;   // LDF only
        logic [7:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

endpackage

//--- design/cpu_top.sv
// core top level
// sequencer, register banks, read mux and ALU on one 16-bit RAM port
// with a combinational register dump port
`timescale 1ns/100ps

module cpu_top import cpu_cfg_pkg::*, cpu_isa_pkg::*; #(
    parameter int N_BANKS = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,

    output logic [ADDR_W-1:0] ram_addr,
    input  logic [DATA_W-1:0] ram_dout,
    output logic [DATA_W-1:0] ram_din,
    output logic [1:0]        ram_we,

    // register dump
    input  logic [7:0]        dmp_addr,
    output logic [7:0]        dmp_din,

    output logic              halted
);

    localparam int RFP_W = $clog2(N_BANKS);

    logic [RFP_W-1:0]     rfp;
    logic                 reg_we;
    logic [REG_SEL_W-1:0] reg_wsel, src_sel, dst_sel;
    logic [DATA_W-1:0]    reg_wdata, src_out, dst_out, alu_dout;
    opcode_e              alu_op;
    logic [7:0]           flags;
    logic                 nx_z, nx_c;

    logic [N_BANKS-1:0][REGS_PER_BANK-1:0][DATA_W-1:0] bank_regs;

    cpu_ctrl #(.N_BANKS(N_BANKS)) u_ctrl (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .cen        ( cen           ),
        .ram_dout   ( ram_dout      ),
        .dst_out    ( dst_out       ),
        .alu_dout   ( alu_dout      ),
        .nx_z       ( nx_z          ),
        .nx_c       ( nx_c          ),
        .ram_addr   ( ram_addr      ),
        .ram_din    ( ram_din       ),
        .ram_we     ( ram_we        ),
        .rfp        ( rfp           ),
        .reg_we     ( reg_we        ),
        .reg_wsel   ( reg_wsel      ),
        .src_sel    ( src_sel       ),
        .dst_sel    ( dst_sel       ),
        .reg_wdata  ( reg_wdata     ),
        .alu_op     ( alu_op        ),
        .flags      ( flags         ),
        .halted     ( halted        )
    );

    // one bank per register file pointer value
    for (genvar g = 0; g < N_BANKS; g++) begin : g_bank
        reg_bank #(.N_BANKS(N_BANKS), .BANK_ID(g)) u_bank (
            .clk        ( clk           ),
            .rst_n      ( rst_n         ),
            .cen        ( cen           ),
            .rfp        ( rfp           ),
            .reg_we     ( reg_we        ),
            .reg_wsel   ( reg_wsel      ),
            .reg_wdata  ( reg_wdata     ),
            .regs       ( bank_regs[g]  )
        );
    end

    reg_read_mux #(.N_BANKS(N_BANKS)) u_rdmux (
        .bank_regs  ( bank_regs     ),
        .rfp        ( rfp           ),
        .src_sel    ( src_sel       ),
        .dst_sel    ( dst_sel       ),
        .dmp_addr   ( dmp_addr      ),
        .flags      ( flags         ),
        .src_out    ( src_out       ),
        .dst_out    ( dst_out       ),
        .dmp_din    ( dmp_din       )
    );

    cpu_alu u_alu (
        .alu_op     ( alu_op        ),
        .op0        ( dst_out       ),
        .op1        ( src_out       ),
        .alu_dout   ( alu_dout      ),
        .nx_z       ( nx_z          ),
        .nx_c       ( nx_c          )
    );

endmodule

//--- design/reg_bank.sv
// one bank of four general registers
// written through the shared write port when the bank pointer matches
`timescale 1ns/100ps

module reg_bank import cpu_cfg_pkg::*; #(
    parameter int N_BANKS = 4,
    parameter int BANK_ID = 0,
    localparam int RFP_W = $clog2(N_BANKS)
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   cen,

    input  logic [RFP_W-1:0]                       rfp,
    input  logic                                   reg_we,
    input  logic [REG_SEL_W-1:0]                   reg_wsel,
    input  logic [DATA_W-1:0]                      reg_wdata,

    output logic [REGS_PER_BANK-1:0][DATA_W-1:0]   regs
);

    localparam logic [RFP_W-1:0] BANK_SEL = RFP_W'(BANK_ID);

    logic bank_hit;

    // only the bank under the pointer takes the write
    assign bank_hit = (rfp == BANK_SEL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (cen && reg_we && bank_hit) begin
            regs[reg_wsel] <= reg_wdata;
        end
    end

endmodule

//--- design/reg_read_mux.sv
// register read side
// operand selection from the active bank and the byte-wide dump port
`timescale 1ns/100ps

module reg_read_mux import cpu_cfg_pkg::*; #(
    parameter int N_BANKS = 4,
    localparam int RFP_W = $clog2(N_BANKS)
) (
    input  logic [N_BANKS-1:0][REGS_PER_BANK-1:0][DATA_W-1:0] bank_regs,
    input  logic [RFP_W-1:0]     rfp,
    input  logic [REG_SEL_W-1:0] src_sel,
    input  logic [REG_SEL_W-1:0] dst_sel,
    input  logic [7:0]           dmp_addr,
    input  logic [7:0]           flags,

    output logic [DATA_W-1:0]    src_out,
    output logic [DATA_W-1:0]    dst_out,
    output logic [7:0]           dmp_din
);

    logic [1:0]           dmp_bank;
    logic [REG_SEL_W-1:0] dmp_reg;
    logic [DATA_W-1:0]    dmp_word;

    assign src_out = bank_regs[rfp][src_sel];
    assign dst_out = bank_regs[rfp][dst_sel];

    // bank in dump address bits [4:3], register in [2:1], high byte in [0]
    assign dmp_bank = dmp_addr[4:3];
    assign dmp_reg  = dmp_addr[2:1];

    // banks beyond N_BANKS read as zero
    assign dmp_word = (32'(dmp_bank) < N_BANKS) ?
                      bank_regs[dmp_bank[RFP_W-1:0]][dmp_reg] : '0;

    always_comb begin
        if (dmp_addr == DMP_FLAGS_ADDR) begin
            dmp_din = flags;
        end else if (dmp_addr[7:5] != 3'd0) begin
            dmp_din = '0;
        end else if (dmp_addr[0]) begin
            dmp_din = dmp_word[DATA_W-1:8];
        end else begin
            dmp_din = dmp_word[7:0];
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module cpu_tb -o cpu_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1
grep -q "Something failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Everything OK" sim.log || { echo "FAIL, run did not complete"; exit 1; }
echo "PASS"

//--- sim/cpu_asserts.sv
// concurrent checks on the core's RAM strobe, halt level
// and output stability while the clock enable is low
`timescale 1ns/100ps

module cpu_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        cen,
    input logic [23:0] ram_addr,
    input logic [1:0]  ram_we,
    input logic        halted
);

    // byte enables only come as a full word
    a_we_word: assert property (@(posedge clk) disable iff (!rst_n)
        ram_we == 2'b00 || ram_we == 2'b11)
        else $error("ram_we carries a partial byte enable");

    a_we_reset: assert property (@(posedge clk) !rst_n |-> ram_we == 2'b00)
        else $error("ram_we active during reset");

    a_halt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else $error("halted dropped without reset");

    // nothing moves on an edge with cen low
    a_cen_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        !cen |=> $stable(ram_addr) && $stable(ram_we) && $stable(halted))
        else $error("outputs changed while cen was low");

endmodule

bind cpu_top cpu_asserts asserts_inst (
    .clk(clk), .rst_n(rst_n), .cen(cen), .ram_addr(ram_addr),
    .ram_we(ram_we), .halted(halted)
);

//--- sim/cpu_tb.sv
// directed testbench for the core
// clock, reset, 256-word RAM model, cen throttling LFSR, test tasks
`timescale 1ns/100ps

module cpu_tb import cpu_isa_pkg::*; ();

    // instructions of all programs including both runs of the throttled test
    localparam int TOTAL_INSTR = 66;
    localparam int N_RUNS = 10;
    localparam real WATCHDOG_NS = (TOTAL_INSTR * 8 * 4 + N_RUNS * 200) * 4.0;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic cen = 1'b1;
    logic [7:0] dmp_addr = 8'h00;
    logic [15:0] ram_dout = 16'h0000;
    logic [23:0] ram_addr;
    logic [15:0] ram_din;
    logic [1:0] ram_we;
    logic [7:0] dmp_din;
    logic halted;

    logic [15:0] mem [256];
    logic fill_req = 1'b0;
    logic load_en = 1'b0;
    logic throttle = 1'b0;
    logic [7:0] load_addr = 8'h00;
    logic [15:0] load_data = 16'h0000;
    logic [31:0] lfsr = 32'h96c7588a;
    logic [15:0] prog [$];
    logic [7:0] snap [2][33];
    int err_count = 0;

    localparam logic [15:0] HLT = 16'hf000;

    cpu_top #(.N_BANKS(4)) cpu_top_inst (.*);

    initial forever #2 clk = ~clk;

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'ha3000000;
        return b;
    endfunction

    always @(posedge clk) cen <= throttle ? lfsr_bit() : 1'b1;

    // RAM model with a preload port used while the core is halted or in reset
    always @(posedge clk) begin
        if (fill_req) begin
            for (int a = 0; a < 256; a++) mem[a] <= {a[7:0] ^ 8'h5a, ~a[7:0]};
        end else if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (cen) begin
            if (ram_we == 2'b11) mem[ram_addr[7:0]] <= ram_din;
            ram_dout <= mem[ram_addr[7:0]];
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $fatal(1);
    end

    function automatic logic [15:0] enc_r(opcode_e op, logic [1:0] d, logic [1:0] s);
        return {op, d, s, 8'h00};
    endfunction

    function automatic logic [15:0] enc_i(opcode_e op, logic [1:0] d, logic [1:0] b,
                                          logic [7:0] imm);
        return {op, d, b, imm};
    endfunction

    // flag byte from a 17-bit result with carry or borrow in bit 16
    function automatic logic [7:0] flag_byte(logic [16:0] wide);
        return {6'b0, wide[16], wide[15:0] == 16'h0000};
    endfunction

    task automatic check_eq(string name, logic [15:0] got, logic [15:0] exp);
        assert (got === exp) else begin
            err_count++;
            $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // preload the program and an optional data word, then reset and run to HALT
    task automatic run_prog(logic [7:0] d_addr, logic [15:0] d_val);
        int cycles;
        @(posedge clk) fill_req <= 1'b1;
        @(posedge clk) fill_req <= 1'b0;
        foreach (prog[k]) begin
            load_en <= 1'b1;
            load_addr <= 8'(k);
            load_data <= prog[k];
            @(posedge clk);
        end
        load_addr <= d_addr;
        load_data <= d_val;
        @(posedge clk) load_en <= 1'b0;
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (!halted) begin
            @(posedge clk);
            cycles++;
            assert (cycles < prog.size() * 32 + 16) else begin
                err_count++;
                $display("core did not reach HALT in time");
                $display("Something failed");
                $fatal(1);
            end
        end
    endtask

    task automatic read_reg(int bank, int r, output logic [15:0] val);
        @(posedge clk) dmp_addr <= {3'b000, 2'(bank), 2'(r), 1'b0};
        @(negedge clk) val[7:0] = dmp_din;
        @(posedge clk) dmp_addr <= {3'b000, 2'(bank), 2'(r), 1'b1};
        @(negedge clk) val[15:8] = dmp_din;
    endtask

    task automatic check_reg(int bank, int r, logic [15:0] exp);
        logic [15:0] v;
        read_reg(bank, r, v);
        check_eq($sformatf("bank%0d r%0d", bank, r), v, exp);
    endtask

    task automatic check_flags(logic [7:0] exp);
        @(posedge clk) dmp_addr <= 8'h20;
        @(negedge clk) check_eq("flags", {8'h00, dmp_din}, {8'h00, exp});
    endtask

    task automatic alu_results();
        logic [15:0] a, b, r0, r2, r3;
        a = 16'h00c8;
        b = 16'h005a;
        r0 = a + b;
        r2 = (r0 - b) & b;
        r3 = 16'h003c ^ b;
        prog = '{enc_i(OP_LDI, 0, 0, 8'hc8), enc_i(OP_LDI, 1, 0, 8'h5a),
                 enc_r(OP_ADD, 0, 1), enc_r(OP_MOV, 2, 0), enc_r(OP_SUB, 2, 1),
                 enc_r(OP_AND, 2, 1), enc_i(OP_LDI, 3, 0, 8'h3c),
                 enc_r(OP_XOR, 3, 1), HLT};
        run_prog(8'hff, 16'h0000);
        check_reg(0, 0, r0);
        check_reg(0, 1, b);
        check_reg(0, 2, r2);
        check_reg(0, 3, r3);
        check_flags(flag_byte({1'b0, r3}));
    endtask

    task automatic flag_updates();
        logic [16:0] borrow, carry;
        borrow = 17'h00000 - 17'h00001;
        carry = {1'b0, borrow[15:0]} + 17'h00001;
        prog = '{enc_i(OP_LDI, 1, 0, 8'h01), enc_r(OP_SUB, 0, 1), HLT};
        run_prog(8'hff, 16'h0000);
        check_flags(flag_byte(borrow));
        // LDI after the ADD leaves the flags alone
        prog = '{enc_i(OP_LDI, 1, 0, 8'h01), enc_r(OP_SUB, 0, 1), enc_r(OP_ADD, 0, 1),
                 enc_i(OP_LDI, 2, 0, 8'h07), HLT};
        run_prog(8'hff, 16'h0000);
        check_flags(flag_byte(carry));
        prog = '{enc_i(OP_LDI, 1, 0, 8'h01), enc_r(OP_SUB, 0, 1), enc_r(OP_XOR, 2, 2), HLT};
        run_prog(8'hff, 16'h0000);
        check_flags(flag_byte(17'h00000));
        prog = '{enc_i(OP_LDI, 1, 0, 8'h01), enc_r(OP_SUB, 0, 1),
                 enc_i(OP_LDI, 2, 0, 8'hf0), enc_r(OP_AND, 2, 0), HLT};
        run_prog(8'hff, 16'h0000);
        check_flags(flag_byte({1'b0, 16'h00f0 & borrow[15:0]}));
    endtask

    task automatic bank_switching();
        prog.delete();
        for (int b = 0; b < 4; b++) begin
            prog.push_back(enc_i(OP_LDF, 0, 2'(b), 8'h00));
            prog.push_back(enc_i(OP_LDI, 1, 0, 8'(8'h11 * (b + 1))));
        end
        prog.push_back(HLT);
        run_prog(8'hff, 16'h0000);
        for (int b = 0; b < 4; b++) begin
            for (int r = 0; r < 4; r++) begin
                check_reg(b, r, (r == 1) ? 16'(8'h11 * (b + 1)) : 16'h0000);
            end
        end
    endtask

    task automatic load_store();
        prog = '{enc_i(OP_LDI, 2, 0, 8'ha5), enc_i(OP_ST, 2, 0, 8'h80),
                 enc_i(OP_LD, 3, 0, 8'h90), HLT};
        run_prog(8'h90, 16'hbeef);
        check_eq("mem[80]", mem[8'h80], 16'h00a5);
        check_reg(0, 3, 16'hbeef);
    endtask

    task automatic jump_skip();
        prog = '{enc_i(OP_LDI, 0, 0, 8'h11), enc_i(OP_JP, 0, 0, 8'h03),
                 enc_i(OP_LDI, 1, 0, 8'h22), enc_i(OP_LDI, 2, 0, 8'h44), HLT};
        run_prog(8'hff, 16'h0000);
        check_reg(0, 0, 16'h0011);
        check_reg(0, 1, 16'h0000);
        check_reg(0, 2, 16'h0044);
    endtask

    task automatic take_snapshot(int k);
        for (int a = 0; a < 33; a++) begin
            @(posedge clk) dmp_addr <= (a == 32) ? 8'h20 : 8'(a);
            @(negedge clk) snap[k][a] = dmp_din;
        end
    endtask

    // same combined program with cen high, then with cen from the LFSR
    task automatic cen_throttling();
        prog = '{enc_i(OP_LDI, 0, 0, 8'hc8), enc_i(OP_LDI, 1, 0, 8'h5a),
                 enc_r(OP_ADD, 0, 1), enc_i(OP_LDF, 0, 2, 8'h00),
                 enc_i(OP_LDI, 3, 0, 8'h77), enc_i(OP_ST, 3, 0, 8'h81),
                 enc_i(OP_LD, 2, 0, 8'h91), enc_i(OP_JP, 0, 0, 8'h09),
                 enc_i(OP_LDI, 1, 0, 8'hee), enc_r(OP_XOR, 2, 3), HLT};
        for (int k = 0; k < 2; k++) begin
            throttle <= (k == 1);
            run_prog(8'h91, 16'h1234);
            check_eq("mem[81]", mem[8'h81], 16'h0077);
            check_reg(2, 2, 16'h1234 ^ 16'h0077);
            take_snapshot(k);
        end
        throttle <= 1'b0;
        for (int a = 0; a < 33; a++) begin
            check_eq($sformatf("dump byte %0d", a), {8'h00, snap[1][a]}, {8'h00, snap[0][a]});
        end
    endtask

    initial begin
        alu_results();
        flag_updates();
        bank_switching();
        load_store();
        jump_skip();
        cen_throttling();
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- src.f
design/cpu_cfg_pkg.sv
design/cpu_isa_pkg.sv
design/cpu_alu.sv
design/reg_bank.sv
design/reg_read_mux.sv
design/cpu_ctrl.sv
design/cpu_top.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv
